//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module gpuTb -f tb.f -o gpuSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/gpuSim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- tb.f
verilog/gpuPkg.sv
verilog/ucodeStore.sv
verilog/gpuDecode.sv
verilog/gpuExecute.sv
verilog/gpuResult.sv
verilog/gpuTop.sv
verification/gpu_assertions.sv
verification/gpuTb.sv

//--- verification/gpuTb.sv
module gpuTb;
  timeunit 1ns;
  timeprecision 100ps;

  import gpuPkg::*;

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 4;
  localparam int progLen     = 200;
  localparam int mcuWrites   = 18;   // 16 selects, enable write, one settle cycle
  localparam int runCycles   = 600;
  localparam int totalCycles = resetCycles + progLen + 1 + mcuWrites + runCycles;

  logic   iClock;
  logic   arstN;
  logic   [3:0] mcuRegSelect;
  byteT   mcuWriteData;
  logic   mcuWe;
  logic   ucodeWe;
  pcT     ucodeAddr;
  uopT    ucodeData;
  logic   fbValid;
  logic   fbReady;
  fbAddrT fbAddr;
  pixRowT fbData;
  byteT   stat;
  byteT   ly;
  byteT   lcdc;

  // reference model state
  dataT   mReg [numRegs];
  uopT    prog [ucodeDepth];   // copy of the loaded program
  logic   mZf;
  pcT     mPc;
  fbAddrT mCount;
  logic   mValid;
  fbAddrT mAddr;
  pixRowT mData;
  int     modelRows;   // rows the model put in the output slot
  int     dutXfers;

  // inputs as the DUT samples them at the coming edge
  logic       curWe;
  logic [3:0] curSel;
  byteT       curData;
  logic       curReady;

  logic [15:0] lfsr = 16'd24;

  gpuTop DUT (.iClock, .arstN, .mcuRegSelect, .mcuWriteData, .mcuWe, .ucodeWe, .ucodeAddr,
              .ucodeData, .fbValid, .fbReady, .fbAddr, .fbData, .stat, .ly, .lcdc);

  initial
  begin
    iClock = 1'b0;
    forever
    begin
      #(clkPeriod / 2) iClock = ~iClock;
    end
  end

  //////////////////////////////
  // random source
  //////////////////////////////
  function automatic logic lfsrBit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // x^16+x^14+x^13+x^11+1
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsrBit()};
    end
    return v;
  endfunction

  //////////////////////////////
  // reporting and compares
  //////////////////////////////
  task automatic abortRun();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compareByte(string name, byteT exp, byteT act);
    if (act !== exp)
    begin
      $display("ERR %s expected %h got %h", name, exp, act);
      abortRun();
    end
  endtask

  task automatic compareBit(string name, logic exp, logic act);
    if (act !== exp)
    begin
      $display("ERR %s expected %h got %h", name, exp, act);
      abortRun();
    end
  endtask

  task automatic compareAddr(string name, fbAddrT exp, fbAddrT act);
    if (act !== exp)
    begin
      $display("ERR %s expected %h got %h", name, exp, act);
      abortRun();
    end
  endtask

  task automatic compareRow(string name, pixRowT exp, pixRowT act);
    if (act !== exp)
    begin
      $display("ERR %s expected %h got %h", name, exp, act);
      abortRun();
    end
  endtask

  task automatic compareCount(string name, int exp, int act);
    if (act != exp)
    begin
      $display("ERR %s expected %h got %h", name, exp, act);
      abortRun();
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic dataT readModel(regSelT s);
    return (s <= regR6) ? mReg[s] : 16'h0000;  // holes read zero
  endfunction

  // engine may only touch stat, ly and the work registers
  function automatic logic writable(regSelT s);
    return (s == regStat) || (s == regLy) || ((s >= regBh) && (s <= regR6));
  endfunction

  function automatic pixRowT composeRow();
    pixRowT row;
    pixT    sIdx;
    pixT    bIdx;
    byteT   pal;
    row = '0;
    for (int i = 0; i < 8; i++)
    begin
      sIdx = {mReg[regSh][i], mReg[regSl][i]};
      bIdx = {mReg[regBh][i], mReg[regBl][i]};
      if (sIdx != transparentIdx)
      begin
        pal = mReg[regSprInfo][sprPaletteBit] ? mReg[regObp1][7:0] : mReg[regObp0][7:0];
      end
      else
      begin
        pal  = mReg[regBgp][7:0];  // background shows through
        sIdx = bIdx;
      end
      row[2*i +: 2] = 2'(pal >> (2 * sIdx));
    end
    return row;
  endfunction

  task automatic modelStep();
    uopT  u;
    opT   op;
    logic act;
    logic stl;
    logic wr;
    logic fbw;
    logic inc;
    logic jmp;
    dataT a;
    dataT b;
    dataT res;
    dataT litW;
    act  = mReg[regLcdc][lcdcEnableBit];
    stl  = mValid && !curReady;
    u    = prog[mPc];
    op   = act ? u.op : opNop;
    litW = {6'd0, u.src1, u.src0};
    a    = readModel(u.src0);
    b    = readModel(((op == opAddl) || (op == opSubl)) ? u.dst : u.src1);
    wr   = op inside {opWrr, opWrl, opAdd, opSub, opAnd, opShl, opAddl, opSubl};
    fbw  = (op == opWfBuffer);
    inc  = (op == opIncFbAddr);
    jmp  = (op == opGoto) || ((op == opJz) && mZf) || ((op == opJnz) && !mZf);
    case (op)
      opWrl:   res = litW;
      opAdd:   res = b + a;
      opSub:   res = b - a;
      opAnd:   res = b & a;
      opShl:   res = b << u.src0[3:0];
      opAddl:  res = b + litW;
      opSubl:  res = b - litW;
      default: res = b;  // wrr copy
    endcase
    // blocked output, uop retried next cycle
    wr  = wr && !stl;
    fbw = fbw && !stl;
    inc = inc && !stl;
    jmp = jmp && !stl;
    if (fbw)
    begin
      mAddr  = mCount;
      mData  = composeRow();  // registers before this edge
      mValid = 1'b1;
      modelRows++;
    end
    else if (curReady)
    begin
      mValid = 1'b0;
    end
    if (inc)
    begin
      mCount = mCount + 13'd1;
    end
    if (wr)
    begin
      mZf = (res == 16'h0000);
      if (writable(u.dst))
      begin
        mReg[u.dst] = (u.dst < regSprInfo) ? {8'h00, res[7:0]} : res;
      end
    end
    if (curWe && (curSel <= 4'd11) && (curSel != 4'd1) && (curSel != 4'd4))
    begin
      mReg[curSel] = {8'h00, curData};
    end
    if (!act)
    begin
      mPc = '0;
    end
    else if (!stl)
    begin
      mPc = jmp ? litW[7:0] : mPc + 8'd1;
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////
  function automatic regSelT pickDst();
    logic [1:0] r;
    r = 2'(randBits(2));
    case (r)
      2'd0:    return regStat;
      2'd1:    return regLy;
      default: return 5'd12 + 5'(randBits(4));  // work regs, some past the map
    endcase
  endfunction

  function automatic uopT makeUop(int a);
    uopT        u;
    logic [3:0] k;
    int         tgt;
    k      = 4'(randBits(4));
    u.dst  = pickDst();
    u.src1 = 5'(randBits(5));
    u.src0 = 5'(randBits(5));
    u.op   = (k < 4'd2) ? opWfBuffer : opT'(k);  // 14 and 15 are spare codes
    tgt    = a + 1 + int'(randBits(3));          // short forward hop
    if (tgt > progLen - 1)
    begin
      tgt = progLen - 1;
    end
    if (a == progLen - 1)
    begin
      u.op = opGoto;  // park on itself
      tgt  = a;
    end
    if ((u.op == opJz) || (u.op == opJnz) || (u.op == opGoto))
    begin
      u.src0      = tgt[4:0];
      u.src1[2:0] = tgt[7:5];
    end
    return u;
  endfunction

  task automatic checkOutputs();
    compareByte("lcdc", mReg[regLcdc][7:0], lcdc);
    compareByte("stat", mReg[regStat][7:0], stat);
    compareByte("ly", mReg[regLy][7:0], ly);
    compareBit("fbValid", mValid, fbValid);
    if (mValid)
    begin
      compareAddr("fbAddr", mAddr, fbAddr);
      compareRow("fbData", mData, fbData);
    end
    if (fbValid && fbReady)
    begin
      dutXfers++;  // taken at the coming edge
    end
  endtask

  // one clock: model follows the edge, new inputs go out, outputs checked mid cycle
  task automatic runCycle(logic we, logic [3:0] sel, byteT data, logic ready);
    @(posedge iClock);
    modelStep();
    mcuWe        <= we;
    mcuRegSelect <= sel;
    mcuWriteData <= data;
    fbReady      <= ready;
    curWe    = we;
    curSel   = sel;
    curData  = data;
    curReady = ready;
    @(negedge iClock);
    checkOutputs();
  endtask

  task automatic loadProgram();
    uopT u;
    for (int a = 0; a < progLen; a++)
    begin
      u       = makeUop(a);
      prog[a] = u;
      @(posedge iClock);
      ucodeWe   <= 1'b1;
      ucodeAddr <= 8'(a);
      ucodeData <= u;
    end
    @(posedge iClock);
    ucodeWe <= 1'b0;
  endtask

  task automatic writeLcdRegs();
    byteT v;
    byteT lcdcVal;
    lcdcVal = '0;
    for (int s = 0; s < 16; s++)
    begin
      v = 8'(randBits(8));
      if (s == 0)
      begin
        v[lcdcEnableBit] = 1'b0;  // engine stays off for now
        lcdcVal = v;
      end
      runCycle(1'b1, 4'(s), v, 1'b1);
    end
    lcdcVal[lcdcEnableBit] = 1'b1;
    runCycle(1'b1, 4'd0, lcdcVal, 1'b1);
    runCycle(1'b0, 4'd0, 8'h00, 1'b1);
    compareByte("lcdc", lcdcVal, lcdc);
    compareByte("stat", 8'h00, stat);  // mcu cannot reach stat or ly
    compareByte("ly", 8'h00, ly);
  endtask

  //////////////////////////////
  // watchdog
  //////////////////////////////
  initial
  begin
    #(2 * totalCycles * clkPeriod);
    $display("timeout: simulation still running after %0d clock cycles", 2 * totalCycles);
    abortRun();
  end

  initial
  begin
    arstN        = 1'b0;
    mcuRegSelect = '0;
    mcuWriteData = '0;
    mcuWe        = 1'b0;
    ucodeWe      = 1'b0;
    ucodeAddr    = '0;
    ucodeData    = '0;
    fbReady      = 1'b0;
    curWe        = 1'b0;
    curSel       = '0;
    curData      = '0;
    curReady     = 1'b0;
    for (int i = 0; i < numRegs; i++)
    begin
      mReg[i] = '0;
    end
    for (int i = 0; i < ucodeDepth; i++)
    begin
      prog[i] = '0;
    end
    mZf       = 1'b0;
    mPc       = '0;
    mCount    = '0;
    mValid    = 1'b0;
    mAddr     = '0;
    mData     = '0;
    modelRows = 0;
    dutXfers  = 0;

    repeat (resetCycles) @(posedge iClock);
    arstN <= 1'b1;

    loadProgram();
    writeLcdRegs();
    for (int c = 0; c < runCycles; c++)
    begin
      runCycle(1'b0, 4'd0, 8'h00, lfsrBit() | lfsrBit());  // ready about 3 in 4
    end

    // a row still waiting on fbReady has not been taken yet
    compareCount("transfers", modelRows - ((mValid && !curReady) ? 1 : 0), dutXfers);
    $display("%0d framebuffer rows transferred", dutXfers);
    if (DUT.uResult.uAssert.failCount == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verification/gpu_assertions.sv
module gpuAssertions
(
  input logic            iClock,
  input logic            arstN,
  input logic            fbValid,
  input logic            fbReady,
  input gpuPkg::fbAddrT  fbAddr,
  input gpuPkg::pixRowT  fbData
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;  // summed up by the testbench

  // output slot still empty one edge out of reset
  validClear: assert property (@(posedge iClock) $rose(arstN) |=> !fbValid)
    else
    begin
      $error("fbValid set right after reset");
      failCount++;
    end

  // payload frozen while blocked
  payloadHold: assert property (@(posedge iClock) disable iff (!arstN)
                                (fbValid && !fbReady) |=> ($stable(fbAddr) && $stable(fbData)))
    else
    begin
      $error("fbAddr or fbData changed while waiting for fbReady");
      failCount++;
    end

  validHold: assert property (@(posedge iClock) disable iff (!arstN)
                              (fbValid && !fbReady) |=> fbValid)
    else
    begin
      $error("fbValid dropped without a transfer");
      failCount++;
    end

endmodule

bind gpuResult gpuAssertions uAssert (.iClock, .arstN, .fbValid, .fbReady, .fbAddr, .fbData);

//--- verilog/gpuDecode.sv
module gpuDecode
(
  input  logic            iClock,
  input  logic            arstN,
  input  logic            active,   // lcdc bit 7
  input  logic            stall,    // fb output blocked
  input  logic            jump,     // taken branch from execute
  input  gpuPkg::uopT     uop,
  output gpuPkg::pcT      pc,
  output gpuPkg::opT      op,
  output gpuPkg::regSelT  dst,
  output gpuPkg::litT     lit,
  output gpuPkg::regSelT  rdSel0,
  output gpuPkg::regSelT  rdSel1,
  input  gpuPkg::dataT    rdData0,
  input  gpuPkg::dataT    rdData1,
  output gpuPkg::dataT    op0,
  output gpuPkg::dataT    op1
);
  import gpuPkg::*;

  pcT  jumpTarget;
  logic litForm;  // addl / subl read dst as second operand

  //////////////////////////////
  // program counter
  //////////////////////////////
  assign jumpTarget = lit[7:0];  // low byte of literal

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      pc <= '0;
    end
    else if (!active)
    begin
      pc <= '0;  // parked at entry while lcd off
    end
    else if (!stall)
    begin
      if (jump)
      begin
        pc <= jumpTarget;
      end
      else
      begin
        pc <= pc + 8'd1;  // wraps at 255
      end
    end
    // stalled: hold, same uop is retried
  end

  //////////////////////////////
  // field split
  //////////////////////////////
  // nothing issues while the engine is off
  assign op  = active ? uop.op : opNop;
  assign dst = uop.dst;
  assign lit = {uop.src1, uop.src0};  // src1 and src0 bits double as literal

  assign litForm = (op == opAddl) || (op == opSubl);

  // register read selects
  assign rdSel0 = uop.src0;
  assign rdSel1 = litForm ? uop.dst : uop.src1;  // accumulate into dst

  // operands straight from register file read bus
  assign op0 = rdData0;
  assign op1 = rdData1;

endmodule

//--- verilog/gpuExecute.sv
module gpuExecute
(
  input  logic          iClock,
  input  logic          arstN,
  input  logic          stall,
  input  gpuPkg::opT    op,
  input  gpuPkg::litT   lit,
  input  gpuPkg::dataT  op0,
  input  gpuPkg::dataT  op1,
  output gpuPkg::dataT  result,
  output logic          regWe,
  output logic          fbWrite,
  output logic          fbIncAddr,
  output logic          jump
);
  import gpuPkg::*;

  dataT litWide;      // zero extended literal
  logic zFlag;
  logic regWeRaw;
  logic fbWriteRaw;
  logic fbIncRaw;
  logic jumpRaw;

  assign litWide = {6'b0, lit};

  //////////////////////////////
  // alu and control decode
  //////////////////////////////
  always_comb
  begin
    result     = op1;
    regWeRaw   = 1'b0;
    fbWriteRaw = 1'b0;
    fbIncRaw   = 1'b0;
    jumpRaw    = 1'b0;
    case (op)
      opWfBuffer:  fbWriteRaw = 1'b1;
      opIncFbAddr: fbIncRaw   = 1'b1;
      opWrr:       regWeRaw   = 1'b1;  // copy op1
      opWrl:
      begin
        result   = litWide;
        regWeRaw = 1'b1;
      end
      opAdd:
      begin
        result   = op1 + op0;
        regWeRaw = 1'b1;
      end
      opSub:
      begin
        result   = op1 - op0;  // op1 minus op0
        regWeRaw = 1'b1;
      end
      opAnd:
      begin
        result   = op1 & op0;
        regWeRaw = 1'b1;
      end
      opShl:
      begin
        result   = op1 << lit[3:0];  // 4 bit shift amount
        regWeRaw = 1'b1;
      end
      opAddl:
      begin
        result   = op1 + litWide;
        regWeRaw = 1'b1;
      end
      opSubl:
      begin
        result   = op1 - litWide;
        regWeRaw = 1'b1;
      end
      opJz:   jumpRaw = zFlag;
      opJnz:  jumpRaw = ~zFlag;
      opGoto: jumpRaw = 1'b1;
      default: ;  // nop and spare codes
    endcase
  end

  // blocked output retries the uop, so nothing commits
  assign regWe     = regWeRaw & ~stall;
  assign fbWrite   = fbWriteRaw & ~stall;
  assign fbIncAddr = fbIncRaw & ~stall;
  assign jump      = jumpRaw & ~stall;

  // zero flag follows every committed register write
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      zFlag <= 1'b0;
    end
    else if (regWe)
    begin
      zFlag <= (result == 16'h0000);
    end
  end

endmodule

//--- verilog/gpuPkg.sv
package gpuPkg;

  //////////////////////////////
  // datapath types
  //////////////////////////////
  typedef logic [15:0] dataT;    // alu and general register word
  typedef logic [7:0]  byteT;    // lcd register value
  typedef logic [4:0]  regSelT;  // register file index
  typedef logic [7:0]  pcT;      // microcode address
  typedef logic [9:0]  litT;     // uop literal
  typedef logic [12:0] fbAddrT;  // framebuffer row address, wraps at 8191
  typedef logic [1:0]  pixT;     // one colour
  typedef logic [15:0] pixRowT;  // eight pixels, pixel i at [2i+1:2i]

  // opcodes, unlisted codes act as nop
  typedef enum logic [3:0] {
    opNop       = 4'd0,
    opWfBuffer  = 4'd1,   // push composed row to framebuffer
    opIncFbAddr = 4'd2,   // bump framebuffer address
    opWrr       = 4'd3,
    opWrl       = 4'd4,
    opAdd       = 4'd5,
    opSub       = 4'd6,
    opAnd       = 4'd7,
    opShl       = 4'd8,
    opAddl      = 4'd9,
    opSubl      = 4'd10,
    opJz        = 4'd11,
    opJnz       = 4'd12,
    opGoto      = 4'd13
  } opT;

  // 19 bit uop, literal is the low 10 bits
  typedef struct packed {
    opT     op;    // [18:15]
    regSelT dst;   // [14:10]
    regSelT src1;  // [9:5]
    regSelT src0;  // [4:0]
  } uopT;

  //////////////////////////////
  // register map
  //////////////////////////////
  localparam regSelT regLcdc    = 5'd0;
  localparam regSelT regStat    = 5'd1;   // engine only
  localparam regSelT regScy     = 5'd2;
  localparam regSelT regScx     = 5'd3;
  localparam regSelT regLy      = 5'd4;   // engine only
  localparam regSelT regLyc     = 5'd5;
  localparam regSelT regDma     = 5'd6;   // plain storage now
  localparam regSelT regBgp     = 5'd7;
  localparam regSelT regObp0    = 5'd8;
  localparam regSelT regObp1    = 5'd9;
  localparam regSelT regWy      = 5'd10;
  localparam regSelT regWx      = 5'd11;  // last lcd register
  localparam regSelT regBh      = 5'd12;  // tile high byte
  localparam regSelT regBl      = 5'd13;  // tile low byte
  localparam regSelT regSh      = 5'd14;  // sprite high byte
  localparam regSelT regSl      = 5'd15;  // sprite low byte
  localparam regSelT regSprInfo = 5'd16;  // first 16 bit register
  localparam regSelT regR0      = 5'd17;
  localparam regSelT regR1      = 5'd18;
  localparam regSelT regR2      = 5'd19;
  localparam regSelT regR3      = 5'd20;
  localparam regSelT regR4      = 5'd21;
  localparam regSelT regR5      = 5'd22;
  localparam regSelT regR6      = 5'd23;

  localparam int numRegs = 24;  // indices above read zero

  // misc constants
  localparam int  lcdcEnableBit  = 7;     // engine run bit
  localparam int  sprPaletteBit  = 4;     // sprInfo bit, 1 picks obp1
  localparam pixT transparentIdx = 2'd0;  // sprite colour index shown as bg
  localparam int  ucodeDepth     = 256;

endpackage

//--- verilog/gpuResult.sv
module gpuResult
(
  input  logic            iClock,
  input  logic            arstN,
  input  logic [3:0]      mcuRegSelect,
  input  gpuPkg::byteT    mcuWriteData,
  input  logic            mcuWe,
  input  logic            regWe,
  input  gpuPkg::regSelT  dst,
  input  gpuPkg::dataT    result,
  input  gpuPkg::regSelT  rdSel0,
  input  gpuPkg::regSelT  rdSel1,
  output gpuPkg::dataT    rdData0,
  output gpuPkg::dataT    rdData1,
  input  logic            fbWrite,
  input  logic            fbIncAddr,
  input  logic            fbReady,
  output logic            fbValid,
  output gpuPkg::fbAddrT  fbAddr,
  output gpuPkg::pixRowT  fbData,
  output logic            stall,
  output logic            active,
  output gpuPkg::byteT    stat,
  output gpuPkg::byteT    ly,
  output gpuPkg::byteT    lcdc
);
  import gpuPkg::*;

  dataT   regFile [numRegs];
  regSelT mcuSel;
  logic   mcuHit;   // mcu write lands
  logic   gpuHit;   // engine write lands
  fbAddrT fbCount;  // next framebuffer row
  pixRowT pixRow;   // composed row, combinational
  logic   useObp1;

  function automatic pixT palLookup(byteT pal, pixT idx);
    return pal[{idx, 1'b0} +: 2];  // entry idx of the palette
  endfunction

  //////////////////////////////
  // register file
  //////////////////////////////
  assign mcuSel = {1'b0, mcuRegSelect};
  assign mcuHit = mcuWe && (mcuSel <= regWx) && (mcuSel != regStat) && (mcuSel != regLy);
  // engine owns stat, ly and everything past the lcd block
  assign gpuHit = regWe && (dst <= regR6)
                  && ((dst > regWx) || (dst == regStat) || (dst == regLy));

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < numRegs; i++)
      begin
        regFile[i] <= '0;
      end
    end
    else
    begin
      if (mcuHit)
      begin
        regFile[mcuSel] <= {8'h00, mcuWriteData};
      end
      if (gpuHit)  // byte registers keep low byte only
      begin
        regFile[dst] <= (dst < regSprInfo) ? {8'h00, result[7:0]} : result;
      end
    end
  end

  // two read ports, out of range reads zero
  assign rdData0 = (rdSel0 <= regR6) ? regFile[rdSel0] : '0;
  assign rdData1 = (rdSel1 <= regR6) ? regFile[rdSel1] : '0;

  assign lcdc   = regFile[regLcdc][7:0];
  assign stat   = regFile[regStat][7:0];
  assign ly     = regFile[regLy][7:0];
  assign active = lcdc[lcdcEnableBit];

  //////////////////////////////
  // pixel composition
  //////////////////////////////
  assign useObp1 = regFile[regSprInfo][sprPaletteBit];

  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      if ({regFile[regSh][i], regFile[regSl][i]} != transparentIdx)
      begin  // opaque sprite pixel wins
        pixRow[2*i +: 2] = palLookup(useObp1 ? regFile[regObp1][7:0] : regFile[regObp0][7:0],
                                     {regFile[regSh][i], regFile[regSl][i]});
      end
      else
      begin
        pixRow[2*i +: 2] = palLookup(regFile[regBgp][7:0],
                                     {regFile[regBh][i], regFile[regBl][i]});
      end
    end
  end

  //////////////////////////////
  // framebuffer output
  //////////////////////////////
  assign stall = fbValid & ~fbReady;  // one row slot, blocked until taken

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      fbCount <= '0;
      fbValid <= 1'b0;
    end
    else
    begin
      if (fbIncAddr)
      begin
        fbCount <= fbCount + 13'd1;  // wraps after 8191
      end
      if (fbWrite)
      begin
        fbValid <= 1'b1;
      end
      else if (fbReady)
      begin
        fbValid <= 1'b0;  // row accepted
      end
    end
  end

  // payload captured with the uop's view of the registers
  always_ff @(posedge iClock)
  begin
    if (fbWrite)
    begin
      fbAddr <= fbCount;
      fbData <= pixRow;
    end
  end

endmodule

//--- verilog/gpuTop.sv
module gpuTop
(
  input  logic            iClock,
  input  logic            arstN,
  input  logic [3:0]      mcuRegSelect,   // lcd register index
  input  gpuPkg::byteT    mcuWriteData,
  input  logic            mcuWe,
  input  logic            ucodeWe,        // microcode load
  input  gpuPkg::pcT      ucodeAddr,
  input  gpuPkg::uopT     ucodeData,
  output logic            fbValid,
  input  logic            fbReady,
  output gpuPkg::fbAddrT  fbAddr,
  output gpuPkg::pixRowT  fbData,
  output gpuPkg::byteT    stat,
  output gpuPkg::byteT    ly,
  output gpuPkg::byteT    lcdc
);
  import gpuPkg::*;

  pcT     curPc;
  uopT    curUop;
  opT     curOp;
  regSelT curDst;
  litT    curLit;
  regSelT rdSel0;
  regSelT rdSel1;
  dataT   rdData0;
  dataT   rdData1;
  dataT   op0;
  dataT   op1;
  dataT   aluResult;
  logic   regWe;
  logic   fbWrite;
  logic   fbIncAddr;
  logic   jump;
  logic   stall;
  logic   active;

  //////////////////////////////
  // fetch, decode, execute, writeback
  //////////////////////////////
  ucodeStore uStore (.iClock(iClock), .we(ucodeWe), .wrAddr(ucodeAddr), .wrData(ucodeData),
                     .pc(curPc), .uop(curUop));

  gpuDecode uDecode (.iClock(iClock), .arstN(arstN), .active(active), .stall(stall),
                     .jump(jump), .uop(curUop), .pc(curPc), .op(curOp), .dst(curDst),
                     .lit(curLit), .rdSel0(rdSel0), .rdSel1(rdSel1), .rdData0(rdData0),
                     .rdData1(rdData1), .op0(op0), .op1(op1));

  gpuExecute uExec (.iClock(iClock), .arstN(arstN), .stall(stall), .op(curOp), .lit(curLit),
                    .op0(op0), .op1(op1), .result(aluResult), .regWe(regWe),
                    .fbWrite(fbWrite), .fbIncAddr(fbIncAddr), .jump(jump));

  gpuResult uResult (.iClock(iClock), .arstN(arstN), .mcuRegSelect(mcuRegSelect),
                     .mcuWriteData(mcuWriteData), .mcuWe(mcuWe), .regWe(regWe),
                     .dst(curDst), .result(aluResult), .rdSel0(rdSel0), .rdSel1(rdSel1),
                     .rdData0(rdData0), .rdData1(rdData1), .fbWrite(fbWrite),
                     .fbIncAddr(fbIncAddr), .fbReady(fbReady), .fbValid(fbValid),
                     .fbAddr(fbAddr), .fbData(fbData), .stall(stall), .active(active),
                     .stat(stat), .ly(ly), .lcdc(lcdc));

endmodule

//--- verilog/ucodeStore.sv
module ucodeStore
(
  input  logic         iClock,
  input  logic         we,      // mcu load strobe
  input  gpuPkg::pcT   wrAddr,
  input  gpuPkg::uopT  wrData,
  input  gpuPkg::pcT   pc,      // sequencer fetch address
  output gpuPkg::uopT  uop
);
  import gpuPkg::*;

  // program memory, survives reset
  uopT mem [ucodeDepth];

  //////////////////////////////
  // load port
  //////////////////////////////
  always_ff @(posedge iClock)
  begin
    if (we)
    begin
      mem[wrAddr] <= wrData;  // mcu writes while engine idle
    end
  end

  // fetch is combinational so a uop runs in its own cycle
  assign uop = mem[pc];

endmodule
